/* design/cache_macros.svh */
`ifndef CACHE_MACROS_SVH
`define CACHE_MACROS_SVH

// address split for a 64-line direct-mapped cache
// over a 16-bit word address space

// line index width, 64 lines
`define CACHE_INDEX_BITS 6

// tag width, upper part of the word address
`define CACHE_TAG_BITS 10

// data word width
`define WORD_BITS 32

// edges from a memory strobe to its ready pulse
`define MEM_LATENCY 4

`endif

/* design/cache_pkg.sv */
`include "cache_macros.svh"

package cache_pkg;

    // one data word
    typedef logic [`WORD_BITS-1:0] word_t;

    // word address, tag above index
    typedef logic [`CACHE_TAG_BITS+`CACHE_INDEX_BITS-1:0] word_addr_t;

    // line index into the cache array
    typedef logic [`CACHE_INDEX_BITS-1:0] cache_index_t;

    // stored or compared tag
    typedef logic [`CACHE_TAG_BITS-1:0] cache_tag_t;

    // controller states
    typedef enum logic [1:0] {
        ST_IDLE,
        ST_LOOKUP,
        ST_WRITEBACK,
        ST_REFILL
    } ctrl_state_t;

endpackage

/* design/cache_array.sv */
`timescale 1ns/1ps
`include "cache_macros.svh"

module cache_array (
    input  logic                  clk,
    input  logic                  arst_n,
    input  cache_pkg::word_addr_t addr,
    input  logic                  we,
    input  cache_pkg::word_t      write_data,
    input  logic                  dirty_in,
    output logic                  hit,
    output logic                  dirty,
    output cache_pkg::word_t      line_data,
    output cache_pkg::word_addr_t victim_addr
);

    // per-line storage
    cache_pkg::word_t      data_mem [1 << `CACHE_INDEX_BITS];
    cache_pkg::cache_tag_t tag_mem  [1 << `CACHE_INDEX_BITS];

    // status bits, one per line
    logic [(1 << `CACHE_INDEX_BITS)-1:0] valid_bits;
    logic [(1 << `CACHE_INDEX_BITS)-1:0] dirty_bits;

    cache_pkg::cache_index_t index;
    cache_pkg::cache_tag_t   tag;

    // split the word address
    assign index = addr[`CACHE_INDEX_BITS-1:0];
    assign tag   = addr[`CACHE_TAG_BITS+`CACHE_INDEX_BITS-1:`CACHE_INDEX_BITS];

    // lookup results, purely combinational from addr
    assign hit       = valid_bits[index] && (tag_mem[index] == tag);
    assign dirty     = dirty_bits[index];
    assign line_data = data_mem[index];

    // address of the word currently held in the line
    assign victim_addr = {tag_mem[index], index};

    // data and tag written together
    always_ff @(posedge clk)
    begin
        if (we)
        begin
            data_mem[index] <= write_data;
            tag_mem[index]  <= tag;
        end
    end

    // valid and dirty only move on an array write
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            valid_bits <= '0;
            dirty_bits <= '0;
        end
        else if (we)
        begin
            valid_bits[index] <= 1'b1;
            dirty_bits[index] <= dirty_in;
        end
    end

endmodule

/* design/backing_memory.sv */
`timescale 1ns/1ps
`include "cache_macros.svh"

module backing_memory (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  rd,
    input  logic                  wr,
    input  cache_pkg::word_addr_t addr,
    input  cache_pkg::word_t      wdata,
    output cache_pkg::word_t      rdata,
    output logic                  ready
);

    typedef logic [$clog2(`MEM_LATENCY + 1)-1:0] count_t;

    // full word-addressed image
    cache_pkg::word_t mem [1 << (`CACHE_TAG_BITS + `CACHE_INDEX_BITS)];

    // access in progress
    count_t                count;
    logic                  op_wr;
    cache_pkg::word_addr_t op_addr;
    cache_pkg::word_t      op_wdata;
    logic                  last_cycle;

    initial
    begin
        for (int i = 0; i < (1 << (`CACHE_TAG_BITS + `CACHE_INDEX_BITS)); i++)
        begin
            mem[i] = '0;
        end
    end

    // final countdown step, access completes on this edge
    assign last_cycle = (count == count_t'(1));

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            count <= '0;
            op_wr <= 1'b0;
            ready <= 1'b0;
        end
        else
        begin
            ready <= last_cycle;
            if (count == '0)
            begin
                // new strobes only when idle
                if (rd || wr)
                begin
                    count <= count_t'(`MEM_LATENCY);
                    op_wr <= wr;
                end
            end
            else
            begin
                count <= count - 1'b1;
            end
        end
    end

    // latched request payload
    always_ff @(posedge clk)
    begin
        if ((count == '0) && (rd || wr))
        begin
            op_addr  <= addr;
            op_wdata <= wdata;
        end
    end

    // array access at the end of the latency window
    always @(posedge clk)
    begin
        if (last_cycle && op_wr)
            mem[op_addr] <= op_wdata;
        if (last_cycle && !op_wr)
            rdata <= mem[op_addr];
    end

endmodule

/* design/cache_controller.sv */
`timescale 1ns/1ps

module cache_controller (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  rd,
    input  logic                  wr,
    input  cache_pkg::word_addr_t addr,
    input  cache_pkg::word_t      wdata,
    input  logic                  array_hit,
    input  logic                  array_dirty,
    input  cache_pkg::word_t      line_data,
    input  cache_pkg::word_addr_t victim_addr,
    input  cache_pkg::word_t      mem_rdata,
    input  logic                  mem_ready,
    output cache_pkg::word_addr_t array_addr,
    output logic                  array_we,
    output cache_pkg::word_t      write_data,
    output logic                  dirty_in,
    output logic                  mem_rd,
    output logic                  mem_wr,
    output cache_pkg::word_addr_t mem_addr,
    output cache_pkg::word_t      mem_wdata,
    output cache_pkg::word_t      rdata,
    output logic                  hit,
    output logic                  done,
    output logic                  busy
);

    cache_pkg::ctrl_state_t state;
    cache_pkg::ctrl_state_t state_next;

    // latched request
    logic                  req_wr;
    cache_pkg::word_addr_t req_addr;
    cache_pkg::word_t      req_wdata;

    logic accept;
    logic finish;
    logic start_wb;
    logic start_fill;

    assign accept = (state == cache_pkg::ST_IDLE) && (rd || wr);
    assign busy   = (state != cache_pkg::ST_IDLE);

    always_comb
    begin
        state_next = state;
        finish     = 1'b0;
        start_wb   = 1'b0;
        start_fill = 1'b0;
        case (state)
            cache_pkg::ST_IDLE:
            begin
                if (accept)
                    state_next = cache_pkg::ST_LOOKUP;
            end
            cache_pkg::ST_LOOKUP:
            begin
                if (array_hit)
                    finish = 1'b1;
                else if (array_dirty)
                    start_wb = 1'b1;
                else if (req_wr)
                    // one-word line, write miss installs directly
                    finish = 1'b1;
                else
                    start_fill = 1'b1;
            end
            cache_pkg::ST_WRITEBACK:
            begin
                if (mem_ready && req_wr)
                    finish = 1'b1;
                else if (mem_ready)
                    start_fill = 1'b1;
            end
            cache_pkg::ST_REFILL:
            begin
                if (mem_ready)
                    finish = 1'b1;
            end
            default:
            begin
                state_next = cache_pkg::ST_IDLE;
            end
        endcase

        if (finish)
            state_next = cache_pkg::ST_IDLE;
        else if (start_wb)
            state_next = cache_pkg::ST_WRITEBACK;
        else if (start_fill)
            state_next = cache_pkg::ST_REFILL;
    end

    // array side, the request address is always presented
    assign array_addr = req_addr;
    assign array_we   = finish && (req_wr || (state == cache_pkg::ST_REFILL));
    assign write_data = req_wr ? req_wdata : mem_rdata;
    assign dirty_in   = req_wr;

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            state  <= cache_pkg::ST_IDLE;
            req_wr <= 1'b0;
            done   <= 1'b0;
            hit    <= 1'b0;
            mem_rd <= 1'b0;
            mem_wr <= 1'b0;
        end
        else
        begin
            state  <= state_next;
            done   <= finish;
            mem_rd <= start_fill;
            mem_wr <= start_wb;
            if (accept)
                req_wr <= wr;
            if (finish)
                hit <= (state == cache_pkg::ST_LOOKUP) && array_hit;
        end
    end

    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            req_addr  <= addr;
            req_wdata <= wdata;
        end

        // victim goes out first on a dirty miss
        if (start_wb)
        begin
            mem_addr  <= victim_addr;
            mem_wdata <= line_data;
        end
        else if (start_fill)
        begin
            mem_addr <= req_addr;
        end

        if (finish)
        begin
            if (req_wr)
                rdata <= req_wdata;
            else if (state == cache_pkg::ST_REFILL)
                rdata <= mem_rdata;
            else
                rdata <= line_data;
        end
    end

endmodule

/* design/cache_subsystem.sv */
`timescale 1ns/1ps

module cache_subsystem (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  rd,
    input  logic                  wr,
    input  cache_pkg::word_addr_t addr,
    input  cache_pkg::word_t      wdata,
    output cache_pkg::word_t      rdata,
    output logic                  hit,
    output logic                  done,
    output logic                  busy
);

    // controller to array
    cache_pkg::word_addr_t array_addr;
    logic                  array_we;
    cache_pkg::word_t      write_data;
    logic                  dirty_in;
    logic                  array_hit;
    logic                  array_dirty;
    cache_pkg::word_t      line_data;
    cache_pkg::word_addr_t victim_addr;

    // controller to memory
    logic                  mem_rd;
    logic                  mem_wr;
    cache_pkg::word_addr_t mem_addr;
    cache_pkg::word_t      mem_wdata;
    cache_pkg::word_t      mem_rdata;
    logic                  mem_ready;

    cache_controller u_ctrl (
        .clk         (clk),
        .arst_n      (arst_n),
        .rd          (rd),
        .wr          (wr),
        .addr        (addr),
        .wdata       (wdata),
        .array_hit   (array_hit),
        .array_dirty (array_dirty),
        .line_data   (line_data),
        .victim_addr (victim_addr),
        .mem_rdata   (mem_rdata),
        .mem_ready   (mem_ready),
        .array_addr  (array_addr),
        .array_we    (array_we),
        .write_data  (write_data),
        .dirty_in    (dirty_in),
        .mem_rd      (mem_rd),
        .mem_wr      (mem_wr),
        .mem_addr    (mem_addr),
        .mem_wdata   (mem_wdata),
        .rdata       (rdata),
        .hit         (hit),
        .done        (done),
        .busy        (busy)
    );

    cache_array u_array (
        .clk         (clk),
        .arst_n      (arst_n),
        .addr        (array_addr),
        .we          (array_we),
        .write_data  (write_data),
        .dirty_in    (dirty_in),
        .hit         (array_hit),
        .dirty       (array_dirty),
        .line_data   (line_data),
        .victim_addr (victim_addr)
    );

    backing_memory u_mem (
        .clk    (clk),
        .arst_n (arst_n),
        .rd     (mem_rd),
        .wr     (mem_wr),
        .addr   (mem_addr),
        .wdata  (mem_wdata),
        .rdata  (mem_rdata),
        .ready  (mem_ready)
    );

endmodule

/* tests/cache_properties.sv */
`timescale 1ns/1ps

module cache_properties (
    input logic clk,
    input logic arst_n,
    input logic done,
    input logic busy,
    input logic mem_rd,
    input logic mem_wr,
    input logic array_we
);

    // done is a single-cycle pulse
    ap_done_pulse : assert property (
        @(posedge clk) disable iff (!arst_n)
        done |=> !done
    ) else $error("done held high for more than one cycle");

    // memory strobes are exclusive
    ap_mem_exclusive : assert property (
        @(posedge clk) disable iff (!arst_n)
        !(mem_rd && mem_wr)
    ) else $error("mem_rd and mem_wr high together");

    // a response only ever follows a busy cycle
    ap_done_after_busy : assert property (
        @(posedge clk) disable iff (!arst_n)
        done |-> $past(busy)
    ) else $error("done without busy on the previous edge");

    // array writes only happen outside idle
    ap_we_not_idle : assert property (
        @(posedge clk) disable iff (!arst_n)
        array_we |-> busy
    ) else $error("array write while controller idle");

endmodule

/* tests/cache_tb.sv */
`timescale 1ns/1ps
`include "cache_macros.svh"

bind cache_subsystem cache_properties u_props (
    .clk      (clk),
    .arst_n   (arst_n),
    .done     (done),
    .busy     (busy),
    .mem_rd   (mem_rd),
    .mem_wr   (mem_wr),
    .array_we (array_we)
);

module cache_tb;

    localparam int RANDOM_OPS = 200;
    // directed accesses plus the dropped strobe and the quiet window after it
    localparam int DIRECTED_OPS = 11;
    localparam int TOTAL_OPS = DIRECTED_OPS + RANDOM_OPS;
    localparam int OP_CYCLES = 2 * `MEM_LATENCY + 6;
    localparam int LINES = 1 << `CACHE_INDEX_BITS;

    logic                  clk;
    logic                  arst_n;
    logic                  rd;
    logic                  wr;
    cache_pkg::word_addr_t addr;
    cache_pkg::word_t      wdata;
    cache_pkg::word_t      rdata;
    logic                  hit;
    logic                  done;
    logic                  busy;

    // reference model state
    cache_pkg::cache_tag_t m_tag   [LINES];
    cache_pkg::word_t      m_data  [LINES];
    logic                  m_valid [LINES];
    logic                  m_dirty [LINES];
    cache_pkg::word_t      mem_img [cache_pkg::word_addr_t];

    int err_count;
    int tests_passed;
    int tests_failed;

    cache_subsystem DUT (
        .clk    (clk),
        .arst_n (arst_n),
        .rd     (rd),
        .wr     (wr),
        .addr   (addr),
        .wdata  (wdata),
        .rdata  (rdata),
        .hit    (hit),
        .done   (done),
        .busy   (busy)
    );

    always #10 clk = ~clk;

    initial
    begin
        #(longint'(TOTAL_OPS) * OP_CYCLES * 20 * 2);
        $display("watchdog expired before the tests completed");
        $display("STATUS: FAIL");
        $finish;
    end

    task automatic check_word(input string name, input cache_pkg::word_t exp,
                              input cache_pkg::word_t act);
        if (exp !== act)
        begin
            $display("ERROR %s: expected %08h actual %08h", name, exp, act);
            err_count++;
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (exp !== act)
        begin
            $display("ERROR %s: expected %0b actual %0b", name, exp, act);
            err_count++;
        end
    endtask

    // predict the result of one access and update the model
    task automatic model_access(input logic is_wr, input cache_pkg::word_addr_t a,
                                input cache_pkg::word_t d,
                                output cache_pkg::word_t exp_data, output logic exp_hit);
        cache_pkg::cache_index_t idx;
        cache_pkg::cache_tag_t   tg;
        idx = a[`CACHE_INDEX_BITS-1:0];
        tg  = a[`CACHE_TAG_BITS+`CACHE_INDEX_BITS-1:`CACHE_INDEX_BITS];
        exp_hit = m_valid[idx] && (m_tag[idx] == tg);
        if (!exp_hit && m_valid[idx] && m_dirty[idx])
            mem_img[{m_tag[idx], idx}] = m_data[idx];
        if (is_wr)
        begin
            m_data[idx]  = d;
            m_dirty[idx] = 1'b1;
        end
        else if (!exp_hit)
        begin
            m_data[idx]  = mem_img.exists(a) ? mem_img[a] : '0;
            m_dirty[idx] = 1'b0;
        end
        m_tag[idx]   = tg;
        m_valid[idx] = 1'b1;
        exp_data = m_data[idx];
    endtask

    // one strobe then wait for done
    // latency counts edges after the accept edge
    task automatic issue(input logic is_wr, input cache_pkg::word_addr_t a,
                         input cache_pkg::word_t d, output int lat);
        rd    = !is_wr;
        wr    = is_wr;
        addr  = a;
        wdata = d;
        @(negedge clk);
        rd  = 1'b0;
        wr  = 1'b0;
        lat = 0;
        while (!done && lat < 4 * OP_CYCLES)
        begin
            @(negedge clk);
            lat++;
        end
        if (!done)
        begin
            $display("request to %04h never completed", a);
            err_count++;
        end
    endtask

    task automatic run_op(input string name, input logic is_wr,
                          input cache_pkg::word_addr_t a, input cache_pkg::word_t d,
                          output int lat);
        cache_pkg::word_t exp_data;
        logic             exp_hit;
        model_access(is_wr, a, d, exp_data, exp_hit);
        issue(is_wr, a, d, lat);
        check_word(name, exp_data, rdata);
        check_flag(name, exp_hit, hit);
        @(negedge clk);
    endtask

    task automatic report(input string name, input int errs_before);
        if (err_count == errs_before)
        begin
            $display("test %s: passed", name);
            tests_passed++;
        end
        else
        begin
            $display("test %s: failed", name);
            tests_failed++;
        end
    endtask

    task automatic first_miss_after_reset();
        int e;
        int lat;
        e = err_count;
        check_flag("reset_done", 1'b0, done);
        check_flag("reset_busy", 1'b0, busy);
        run_op("first_miss", 1'b0, 16'h0123, '0, lat);
        check_flag("first_miss_hit", 1'b0, hit);
        check_word("first_miss_data", '0, rdata);
        report("reset_first_miss", e);
    endtask

    task automatic read_hit_timing();
        int e;
        int lat;
        e = err_count;
        run_op("read_hit", 1'b0, 16'h0123, '0, lat);
        check_flag("read_hit_latency", 1'b1, lat == 1);
        report("read_hit", e);
    endtask

    task automatic write_hit_readback();
        int e;
        int lat;
        e = err_count;
        run_op("write_hit", 1'b1, 16'h0123, 32'hdead_beef, lat);
        check_flag("write_hit_flag", 1'b1, hit);
        run_op("write_readback", 1'b0, 16'h0123, '0, lat);
        check_word("write_readback_data", 32'hdead_beef, rdata);
        report("write_hit", e);
    endtask

    task automatic dirty_eviction();
        int e;
        int lat;
        e = err_count;
        // index 10 with tags 5 and 6
        run_op("evict_write_a", 1'b1, {10'd5, 6'd10}, 32'h1111_aaaa, lat);
        run_op("evict_write_b", 1'b1, {10'd6, 6'd10}, 32'h2222_bbbb, lat);
        run_op("evict_read_a", 1'b0, {10'd5, 6'd10}, '0, lat);
        check_word("evict_read_a_data", 32'h1111_aaaa, rdata);
        check_flag("evict_read_a_hit", 1'b0, hit);
        report("dirty_evict", e);
    endtask

    task automatic drop_while_busy();
        cache_pkg::word_t exp_data;
        logic             exp_hit;
        int               e;
        int               lat;
        int               n;
        e = err_count;
        model_access(1'b0, {10'd9, 6'd20}, '0, exp_data, exp_hit);
        rd   = 1'b1;
        addr = {10'd9, 6'd20};
        @(negedge clk);
        rd = 1'b0;
        check_flag("busy_high", 1'b1, busy);
        // this write is dropped and the model stays as it is
        wr    = 1'b1;
        addr  = {10'd9, 6'd21};
        wdata = 32'h5555_5555;
        @(negedge clk);
        wr  = 1'b0;
        lat = 0;
        while (!done && lat < 4 * OP_CYCLES)
        begin
            @(negedge clk);
            lat++;
        end
        check_flag("busy_done", 1'b1, done);
        check_word("busy_data", exp_data, rdata);
        check_flag("busy_hit", exp_hit, hit);
        n = 0;
        repeat (OP_CYCLES)
        begin
            @(negedge clk);
            if (done)
                n++;
        end
        if (n != 0)
        begin
            $display("dropped request produced a second done pulse");
            err_count++;
        end
        run_op("busy_check_other", 1'b0, {10'd9, 6'd21}, '0, lat);
        report("busy_drop", e);
    endtask

    task automatic random_traffic();
        cache_pkg::word_addr_t a;
        logic [31:0]           r;
        int                    e;
        int                    lat;
        e = err_count;
        for (int i = 0; i < RANDOM_OPS; i++)
        begin
            r = $urandom;
            a = {8'd0, r[1:0], 3'd0, r[4:2]};
            run_op("random", r[5], a, $urandom, lat);
        end
        report("random", e);
    endtask

    initial
    begin
        void'($urandom(32'hc417));
        clk    = 1'b0;
        arst_n = 1'b0;
        rd     = 1'b0;
        wr     = 1'b0;
        addr   = '0;
        wdata  = '0;
        err_count    = 0;
        tests_passed = 0;
        tests_failed = 0;
        for (int i = 0; i < LINES; i++)
        begin
            m_valid[i] = 1'b0;
            m_dirty[i] = 1'b0;
            m_tag[i]   = '0;
            m_data[i]  = '0;
        end
        repeat (3) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        @(negedge clk);

        first_miss_after_reset();
        read_hit_timing();
        write_hit_readback();
        dirty_eviction();
        drop_while_busy();
        random_traffic();

        $display("tests passed %0d, failed %0d, errors %0d",
                 tests_passed, tests_failed, err_count);
        if (err_count == 0)
            $display("STATUS: PASS");
        else
            $display("STATUS: FAIL");
        $finish;
    end

endmodule

/* list.f */
+incdir+design
design/cache_pkg.sv
design/cache_array.sv
design/backing_memory.sv
design/cache_controller.sv
design/cache_subsystem.sv
tests/cache_properties.sv
tests/cache_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= cache_tb
FLAGS     ?= --binary --timing

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f list.f
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "STATUS: PASS"

clean:
	rm -rf obj_dir
